// File: include/uart_params.svh
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

////////////////////////////////////////////////////////////
// Baud timing
////////////////////////////////////////////////////////////

// Clocks between oversample ticks
// Kept small so a full frame stays short in simulation
`define UART_CLKS_PER_TICK 4

// Oversample ticks per bit period
`define UART_OVERSAMPLE 16

////////////////////////////////////////////////////////////
// Frame format
////////////////////////////////////////////////////////////

// Data bits per frame, 8N1 only
// One start bit and one stop bit are implied by the FSMs
`define UART_DATA_BITS 8

`endif

// File: rtl/uart_pkg.sv
`default_nettype none

`include "uart_params.svh"

package uart_pkg;

	////////////////////////////////////////////////////////////
	// FSM states
	////////////////////////////////////////////////////////////

	// Transmitter states, one per frame section
	typedef enum logic [1:0] {
		TX_IDLE  = 2'd0,
		TX_START = 2'd1,
		TX_DATA  = 2'd2,
		TX_STOP  = 2'd3
	} tx_state_e;

	// Receiver states, same sections seen from the line side
	typedef enum logic [1:0] {
		RX_IDLE  = 2'd0,
		RX_START = 2'd1,
		RX_DATA  = 2'd2,
		RX_STOP  = 2'd3
	} rx_state_e;

	////////////////////////////////////////////////////////////
	// Receive result
	////////////////////////////////////////////////////////////

	// Received byte plus framing status
	// frame_err set when the stop sample was low
	typedef struct packed {
		logic [`UART_DATA_BITS-1:0] data;
		logic                       frame_err;
	} rx_result_t;

endpackage

`default_nettype wire

// File: rtl/baud_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module baud_tick_gen (
	input  wire  clk,
	input  wire  rst_n,
	output logic tick
);

	// Counter sized to hold the reload value
	localparam int CNT_W = $clog2(`UART_CLKS_PER_TICK + 1);
	localparam logic [CNT_W-1:0] CNT_RELOAD = CNT_W'(`UART_CLKS_PER_TICK - 1);

	// Clocks left until the next tick
	logic [CNT_W-1:0] cnt;

	////////////////////////////////////////////////////////////
	// Free running down counter
	////////////////////////////////////////////////////////////

	// Tick is registered and lasts one clock
	// Raised on the clock where the counter reloads
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt  <= CNT_RELOAD;
			tick <= 1'b0;
		end
		else if (cnt == '0)
		begin
			// Period complete, start over
			cnt  <= CNT_RELOAD;
			tick <= 1'b1;
		end
		else
		begin
			cnt  <= cnt - 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_tx (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       tick,
	input  wire                       tx_start,
	input  wire [`UART_DATA_BITS-1:0] tx_data,
	output logic                      tx_serial,
	output logic                      tx_busy,
	output logic                      tx_done
);

	// Counter widths and terminal values
	localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_W  = $clog2(`UART_DATA_BITS);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`UART_OVERSAMPLE - 1);
	localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(`UART_DATA_BITS - 1);

	uart_pkg::tx_state_e        state;
	logic [TICK_W-1:0]          tick_cnt;
	logic [BIT_W-1:0]           bit_cnt;
	logic [`UART_DATA_BITS-1:0] shreg;

	logic accept;
	logic bit_end;
	logic next_bit;

	////////////////////////////////////////////////////////////
	// Control decode
	////////////////////////////////////////////////////////////

	// Strobe taken only while idle and not already holding a byte
	assign accept  = tx_start && !tx_busy;

	// Last tick of the current bit period
	assign bit_end = tick && (tick_cnt == TICK_LAST);

	// Another data bit goes out after this one
	assign next_bit = bit_end && ((state == uart_pkg::TX_START) ||
		((state == uart_pkg::TX_DATA) && (bit_cnt != BIT_LAST)));

	////////////////////////////////////////////////////////////
	// Transmit FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= uart_pkg::TX_IDLE;
			tick_cnt  <= '0;
			bit_cnt   <= '0;
			tx_serial <= 1'b1;
			tx_busy   <= 1'b0;
			tx_done   <= 1'b0;
		end
		else
		begin
			// Done is a single clock pulse
			tx_done <= 1'b0;
			case (state)
				uart_pkg::TX_IDLE:
				begin
					// Busy doubles as the latched strobe
					if (accept)
						tx_busy <= 1'b1;
					else if (tx_busy && tick)
					begin
						// Frame starts on a tick boundary
						state     <= uart_pkg::TX_START;
						tx_serial <= 1'b0;
						tick_cnt  <= '0;
					end
				end
				uart_pkg::TX_START:
				begin
					if (bit_end)
					begin
						// LSB goes first
						state     <= uart_pkg::TX_DATA;
						tx_serial <= shreg[0];
						tick_cnt  <= '0;
						bit_cnt   <= '0;
					end
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				end
				uart_pkg::TX_DATA:
				begin
					if (bit_end)
					begin
						tick_cnt <= '0;
						if (bit_cnt == BIT_LAST)
						begin
							// All data out, stop bit is high
							state     <= uart_pkg::TX_STOP;
							tx_serial <= 1'b1;
						end
						else
						begin
							tx_serial <= shreg[0];
							bit_cnt   <= bit_cnt + 1'b1;
						end
					end
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				end
				uart_pkg::TX_STOP:
				begin
					// Full stop bit before release
					if (bit_end)
					begin
						state    <= uart_pkg::TX_IDLE;
						tick_cnt <= '0;
						tx_busy  <= 1'b0;
						tx_done  <= 1'b1;
					end
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				end
				default:
					state <= uart_pkg::TX_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Shift register
	////////////////////////////////////////////////////////////

	// Loaded on accept, moves right as each bit is driven
	always_ff @(posedge clk)
	begin
		if (accept)
			shreg <= tx_data;
		else if (next_bit)
			shreg <= shreg >> 1;
	end

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_rx (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   tick,
	input  wire                   rx_serial,
	output logic                  rx_valid,
	output uart_pkg::rx_result_t  rx_result
);

	// Counter widths and terminal values
	localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_W  = $clog2(`UART_DATA_BITS);
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`UART_OVERSAMPLE - 1);
	localparam logic [TICK_W-1:0] TICK_HALF = TICK_W'(`UART_OVERSAMPLE / 2 - 1);
	localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(`UART_DATA_BITS - 1);

	uart_pkg::rx_state_e        state;
	logic [TICK_W-1:0]          tick_cnt;
	logic [BIT_W-1:0]           bit_cnt;
	logic [`UART_DATA_BITS-1:0] shreg;

	// Synchronizer stages
	logic rx_meta;
	logic rx_sync;

	logic bit_end;
	logic sample_data;

	////////////////////////////////////////////////////////////
	// Input synchronizer
	////////////////////////////////////////////////////////////

	// Line idles high, so reset to high
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= rx_serial;
			rx_sync <= rx_meta;
		end
	end

	////////////////////////////////////////////////////////////
	// Sample points
	////////////////////////////////////////////////////////////

	// Mid-bit once start has been centered
	assign bit_end = tick && (tick_cnt == TICK_LAST);

	// Data sample, one per data bit
	assign sample_data = bit_end && (state == uart_pkg::RX_DATA);

	////////////////////////////////////////////////////////////
	// Receive FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= uart_pkg::RX_IDLE;
			tick_cnt  <= '0;
			bit_cnt   <= '0;
			rx_valid  <= 1'b0;
			rx_result <= '0;
		end
		else
		begin
			// Valid is a single clock pulse
			rx_valid <= 1'b0;
			case (state)
				uart_pkg::RX_IDLE:
				begin
					// Low on a tick may be a start edge
					if (tick && !rx_sync)
					begin
						state    <= uart_pkg::RX_START;
						tick_cnt <= '0;
					end
				end
				uart_pkg::RX_START:
				begin
					if (tick && (tick_cnt == TICK_HALF))
					begin
						tick_cnt <= '0;
						bit_cnt  <= '0;
						// High at half a bit means a glitch
						if (rx_sync)
							state <= uart_pkg::RX_IDLE;
						else
							state <= uart_pkg::RX_DATA;
					end
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				end
				uart_pkg::RX_DATA:
				begin
					if (bit_end)
					begin
						tick_cnt <= '0;
						if (bit_cnt == BIT_LAST)
							state <= uart_pkg::RX_STOP;
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				end
				uart_pkg::RX_STOP:
				begin
					// Byte delivered even on a bad stop bit
					if (bit_end)
					begin
						state               <= uart_pkg::RX_IDLE;
						tick_cnt            <= '0;
						rx_valid            <= 1'b1;
						rx_result.data      <= shreg;
						rx_result.frame_err <= !rx_sync;
					end
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				end
				default:
					state <= uart_pkg::RX_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Shift register
	////////////////////////////////////////////////////////////

	// LSB arrives first, so fill from the top
	always_ff @(posedge clk)
	begin
		if (sample_data)
			shreg <= {rx_sync, shreg[`UART_DATA_BITS-1:1]};
	end

endmodule

`default_nettype wire

// File: rtl/uart_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module uart_core (
	input  wire                       clk,
	input  wire                       rst_n,
	// Transmit side
	input  wire                       tx_start,
	input  wire [`UART_DATA_BITS-1:0] tx_data,
	output logic                      tx_serial,
	output logic                      tx_busy,
	output logic                      tx_done,
	// Receive side
	input  wire                       rx_serial,
	output logic                      rx_valid,
	output uart_pkg::rx_result_t      rx_result
);

	// Shared oversample time base
	logic tick;

	////////////////////////////////////////////////////////////
	// Baud tick
	////////////////////////////////////////////////////////////

	baud_tick_gen u_tick (
		.clk   (clk),
		.rst_n (rst_n),
		.tick  (tick)
	);

	////////////////////////////////////////////////////////////
	// Serial machines
	////////////////////////////////////////////////////////////

	// Transmitter, paced by the shared tick
	uart_tx u_tx (
		.clk       (clk),
		.rst_n     (rst_n),
		.tick      (tick),
		.tx_start  (tx_start),
		.tx_data   (tx_data),
		.tx_serial (tx_serial),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done)
	);

	// Receiver, independent input pin
	uart_rx u_rx (
		.clk       (clk),
		.rst_n     (rst_n),
		.tick      (tick),
		.rx_serial (rx_serial),
		.rx_valid  (rx_valid),
		.rx_result (rx_result)
	);

endmodule

`default_nettype wire

// File: dv/tb_uart_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_params.svh"

module tb_uart_core;

	// One bit period in clocks
	localparam int BIT_CLKS    = `UART_OVERSAMPLE * `UART_CLKS_PER_TICK;
	// Frames over the whole run without the glitch
	localparam int N_FRAMES    = 18;
	localparam int CYCLE_LIMIT = (N_FRAMES + 4) * 170 * `UART_CLKS_PER_TICK;

	logic                 clk;
	logic                 rst_n;
	logic                 tx_start;
	logic [7:0]           tx_data;
	logic                 tx_serial;
	logic                 tx_busy;
	logic                 tx_done;
	logic                 rx_serial;
	logic                 rx_valid;
	uart_pkg::rx_result_t rx_result;

	// Serial input source is loopback or bit-banged
	logic loop_en;
	logic drv_serial;

	// Expected results and bytes decoded from the line
	logic [7:0]           exp_tx_q[$];
	uart_pkg::rx_result_t exp_rx_q[$];
	logic [7:0]           dec_q[$];
	logic [7:0]           dec_byte;

	int err_cnt      = 0;
	int cycle_cnt    = 0;
	int accepted_cnt = 0;
	int done_cnt     = 0;
	int frames_seen  = 0;
	int rx_valid_cnt = 0;
	int rx_expected  = 0;

	assign rx_serial = loop_en ? tx_serial : drv_serial;

	uart_core UUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.tx_start  (tx_start),
		.tx_data   (tx_data),
		.tx_serial (tx_serial),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.rx_serial (rx_serial),
		.rx_valid  (rx_valid),
		.rx_result (rx_result)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Reference model and checks
	////////////////////////////////////////////////////////////

	// Byte as sent with an error flag for a low stop bit
	function automatic uart_pkg::rx_result_t expect_rx(input logic [7:0] b,
		input logic stop_val);
		uart_pkg::rx_result_t r;
		r.data      = b;
		r.frame_err = !stop_val;
		return r;
	endfunction

	task automatic abort_run;
		err_cnt++;
		$display("SOME TESTS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_rx(input string name, input uart_pkg::rx_result_t exp,
		input uart_pkg::rx_result_t got);
		if (got !== exp)
		begin
			$display("Fail at %0t: %s expected data=%h frame_err=%b, got data=%h frame_err=%b",
				$time, name, exp.data, exp.frame_err, got.data, got.frame_err);
			abort_run();
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
		if (got !== exp)
		begin
			$display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp)
		begin
			$display("Fail at %0t: %s expected %b, got %b", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int got);
		if (got != exp)
		begin
			$display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, got);
			abort_run();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////

	task automatic wait_tx_idle;
		@(negedge clk);
		while (tx_busy)
			@(negedge clk);
	endtask

	// One clock strobe once the transmitter is free
	task automatic send_byte(input logic [7:0] b);
		wait_tx_idle();
		@(posedge clk);
		tx_start <= 1'b1;
		tx_data  <= b;
		exp_tx_q.push_back(b);
		accepted_cnt++;
		@(posedge clk);
		tx_start <= 1'b0;
	endtask

	// Strobe with other data in the middle of a frame
	task automatic pulse_start_busy(input logic [7:0] b);
		@(negedge clk);
		check_bit("tx_busy", 1'b1, tx_busy);
		@(posedge clk);
		tx_start <= 1'b1;
		tx_data  <= b;
		@(posedge clk);
		tx_start <= 1'b0;
	endtask

	task automatic drive_bit(input logic v);
		@(posedge clk);
		drv_serial <= v;
		repeat (BIT_CLKS - 1) @(posedge clk);
	endtask

	// Start, data LSB first, stop, then two idle bits
	task automatic drive_frame(input logic [7:0] b, input logic stop_val);
		int k;
		exp_rx_q.push_back(expect_rx(b, stop_val));
		rx_expected++;
		drive_bit(1'b0);
		for (k = 0; k < 8; k++)
			drive_bit(b[k]);
		drive_bit(stop_val);
		drive_bit(1'b1);
		drive_bit(1'b1);
	endtask

	////////////////////////////////////////////////////////////
	// Line monitor and compare
	////////////////////////////////////////////////////////////

	// Decodes tx_serial at mid-bit from the falling edge
	initial
	begin : tx_monitor
		logic       prev;
		logic [7:0] shift;
		logic       stop_bit;
		int         low_len;
		int         i;
		prev     = 1'b1;
		shift    = '0;
		stop_bit = 1'b1;
		low_len  = 0;
		forever
		begin
			@(negedge clk);
			if (rst_n && prev && !tx_serial)
			begin
				low_len = 0;
				for (i = 1; i <= 9 * BIT_CLKS + BIT_CLKS / 2; i++)
				begin
					@(negedge clk);
					if (low_len == 0 && tx_serial)
						low_len = i;
					// Mid-bit of each data bit and the stop bit
					if (i % BIT_CLKS == BIT_CLKS / 2)
					begin
						if (i / BIT_CLKS == 9)
							stop_bit = tx_serial;
						else if (i / BIT_CLKS >= 1)
							shift[i / BIT_CLKS - 1] = tx_serial;
					end
				end
				check_bit("tx_serial stop bit", 1'b1, stop_bit);
				// Start width only visible when bit 0 is high
				if (shift[0])
					check_count("tx_serial start bit clocks", BIT_CLKS, low_len);
				dec_q.push_back(shift);
				frames_seen++;
			end
			prev = tx_serial;
		end
	end

	always @(negedge clk)
	begin
		if (rst_n && tx_done)
			done_cnt++;
		if (rst_n && rx_valid)
		begin
			rx_valid_cnt++;
			if (exp_rx_q.size() == 0)
			begin
				$display("Error at %0t: rx_valid pulsed with no frame expected", $time);
				abort_run();
			end
			else
				check_rx("rx_result", exp_rx_q.pop_front(), rx_result);
		end
		if (dec_q.size() > 0)
		begin
			dec_byte = dec_q.pop_front();
			if (exp_tx_q.size() == 0)
			begin
				$display("Error at %0t: frame on tx_serial with no byte sent", $time);
				abort_run();
			end
			else
				check_byte("tx_serial byte", exp_tx_q.pop_front(), dec_byte);
		end
	end

	// Watchdog on total run length
	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT)
		begin
			$display("Error: run took longer than %0d cycles, the DUT looks hung", CYCLE_LIMIT);
			abort_run();
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial
	begin : main_seq
		logic [31:0] rnd;
		int          i;
		int          done_base;
		int          frames_base;
		rst_n      = 1'b0;
		tx_start   = 1'b0;
		tx_data    = '0;
		loop_en    = 1'b0;
		drv_serial = 1'b1;
		rnd        = $urandom(32'ha690_d6c3);
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		// Idle outputs after reset
		@(negedge clk);
		check_bit("tx_serial", 1'b1, tx_serial);
		check_bit("tx_busy", 1'b0, tx_busy);
		check_bit("tx_done", 1'b0, tx_done);
		check_bit("rx_valid", 1'b0, rx_valid);
		check_rx("rx_result", '0, rx_result);

		// Back to back transmit with bit 0 high in the first byte
		send_byte(8'h55);
		for (i = 0; i < 5; i++)
		begin
			rnd = $urandom();
			send_byte(rnd[7:0]);
		end

		// Held strobe and strobes while busy are dropped
		wait_tx_idle();
		// Last tx_done pulse is counted one clock earlier
		@(negedge clk);
		done_base   = done_cnt;
		frames_base = frames_seen;
		@(posedge clk);
		tx_start <= 1'b1;
		tx_data  <= 8'hC3;
		exp_tx_q.push_back(8'hC3);
		accepted_cnt++;
		repeat (3) @(posedge clk);
		tx_start <= 1'b0;
		repeat (150) @(posedge clk);
		pulse_start_busy(8'h3C);
		repeat (150) @(posedge clk);
		pulse_start_busy(8'hFF);
		for (i = 0; i < 2; i++)
		begin
			rnd = $urandom();
			send_byte(rnd[7:0]);
		end
		wait_tx_idle();
		@(negedge clk);
		check_count("tx_done pulses", done_base + 3, done_cnt);
		check_count("decoded frames", frames_base + 3, frames_seen);

		// Loopback through the receiver
		@(posedge clk);
		loop_en <= 1'b1;
		for (i = 0; i < 6; i++)
		begin
			rnd = $urandom();
			exp_rx_q.push_back(expect_rx(rnd[7:0], 1'b1));
			rx_expected++;
			send_byte(rnd[7:0]);
		end
		wait_tx_idle();
		@(posedge clk);
		loop_en <= 1'b0;
		check_count("rx_valid pulses", rx_expected, rx_valid_cnt);

		// Low stop bit, then a clean frame
		drive_frame(8'h3C, 1'b0);
		check_count("rx_valid pulses", rx_expected, rx_valid_cnt);
		drive_frame(8'hA7, 1'b1);
		check_count("rx_valid pulses", rx_expected, rx_valid_cnt);

		// Eighth of a bit low is well under a quarter
		@(posedge clk);
		drv_serial <= 1'b0;
		repeat (BIT_CLKS / 8) @(posedge clk);
		drv_serial <= 1'b1;
		repeat (3 * BIT_CLKS) @(posedge clk);
		check_count("rx_valid pulses", rx_expected, rx_valid_cnt);
		rnd = $urandom();
		drive_frame(rnd[7:0], 1'b1);

		// Drain and final tallies
		repeat (BIT_CLKS) @(posedge clk);
		@(negedge clk);
		check_count("rx_valid pulses", rx_expected, rx_valid_cnt);
		check_count("pending tx bytes", 0, exp_tx_q.size());
		check_count("pending rx results", 0, exp_rx_q.size());
		check_count("tx_done pulses", accepted_cnt, done_cnt);
		check_count("decoded frames", accepted_cnt, frames_seen);
		if (err_cnt == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
rtl/uart_pkg.sv
rtl/baud_tick_gen.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_core.sv
dv/tb_uart_core.sv

// File: Makefile
# Verilator flow for the UART core

VERILATOR  ?= verilator
TOP        := tb_uart_core
FILELIST   := list.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := ALL TESTS PASSED
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)
SIM_FLAGS  := --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

# Pass only when the log holds the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
